// File: bench/scrmbl_props.sv
////////////////////////////////////////////////////////////
// handshake and latency properties, bound into scrmbl_fsm
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module scrmbl_props (
  input logic                    clk_i,
  input logic                    rst_ni,
  input scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input logic                    valid_i,
  input logic                    ready_o,
  input logic                    valid_o
);
  import scrmbl_pkg::*;

  logic       accept;
  logic       round_cmd;
  logic [5:0] edges_left;

  assign accept    = valid_i && ready_o;
  // commands that run the cipher
  assign round_cmd = (cmd_i == cmd_encrypt) || (cmd_i == cmd_decrypt) ||
                     (cmd_i == cmd_digest) || (cmd_i == cmd_digest_finalize);

  // edges still to go until the result of the command in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges_left <= '0;
    end else if (accept && round_cmd) begin
      edges_left <= 6'(num_rounds);
    end else if (edges_left != 6'd0) begin
      edges_left <= edges_left - 6'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  a_valid_on_time: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edges_left == 6'd1) |=> valid_o)
    else $error("result valid missing 31 edges after a round command");

  // also rules out a result after LoadShadow or DigestInit
  a_valid_only_when_due: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> ($past(edges_left) == 6'd1))
    else $error("result valid without a round command 31 edges before");

  a_valid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o)
    else $error("result valid held longer than one cycle");

  a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edges_left != 6'd0) |-> !ready_o)
    else $error("ready raised while rounds are still running");

  a_single_stays_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (accept && !round_cmd) |=> (ready_o && !valid_o))
    else $error("single-cycle command left the scrambler busy or gave a result");

endmodule

// File: bench/tb_scrmbl.sv
////////////////////////////////////////////////////////////
// testbench for the scrambler top level
// round trips, key selection and digest runs under random data
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_scrmbl;
  import scrmbl_pkg::*;

  // about 60 round commands of roughly 34 cycles each, with ample margin
  localparam int max_cycles = 5000;

  logic                   clk_i;
  logic                   rst_ni;
  scrmbl_cmd_e            cmd_i;
  logic [sel_width-1:0]   sel_i;
  logic [block_width-1:0] data_i;
  logic                   valid_i;
  logic                   ready_o;
  logic [block_width-1:0] data_o;
  logic                   valid_o;

  int          n_checks = 0;
  int          n_errors = 0;
  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'h44ef_3401;

  scrmbl_top u_dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .sel_i   (sel_i),
    .data_i  (data_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  bind scrmbl_fsm scrmbl_props u_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // watchdog
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_block(output logic [block_width-1:0] b);
    logic [31:0] hi;
    lcg_state = lcg_step(lcg_state);
    hi = lcg_state;
    lcg_state = lcg_step(lcg_state);
    b = {hi, lcg_state};
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] got);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_differ(input string what, input logic [63:0] a, input logic [63:0] b);
    n_checks++;
    assert (a !== b) else begin
      n_errors++;
      $display("at %0t the %s are equal but should differ, both %h", $time, what, a);
    end
  endtask

  // one command, waits for its result; noisy keeps valid_i busy with junk commands
  task automatic issue_cmd(input scrmbl_cmd_e cmd, input logic [sel_width-1:0] sel,
                           input logic [block_width-1:0] data, input bit noisy,
                           output logic [block_width-1:0] result);
    logic [block_width-1:0] junk;
    bit                     is_round;
    is_round = (cmd == cmd_encrypt) || (cmd == cmd_decrypt) ||
               (cmd == cmd_digest) || (cmd == cmd_digest_finalize);
    result = '0;
    @(negedge clk_i);
    while (ready_o !== 1'b1) @(negedge clk_i);
    @(posedge clk_i);
    cmd_i   <= cmd;
    sel_i   <= sel;
    data_i  <= data;
    valid_i <= 1'b1;
    // accepted here
    @(posedge clk_i);
    if (is_round && noisy) begin
      // dropped again two edges before the result
      for (int i = 0; i < num_rounds - 2; i++) begin
        random_block(junk);
        cmd_i  <= scrmbl_cmd_e'(junk[2:0] % 3'd6);
        sel_i  <= junk[9:8];
        data_i <= junk;
        @(posedge clk_i);
      end
    end
    valid_i <= 1'b0;
    if (is_round) begin
      do @(negedge clk_i); while (valid_o !== 1'b1);
      result = data_o;
    end
  endtask

  task automatic round_trip(input logic [sel_width-1:0] sel, input bit noisy);
    logic [block_width-1:0] pt, ct, rt;
    random_block(pt);
    issue_cmd(cmd_encrypt, sel, pt, noisy, ct);
    check_differ("ciphertext and plaintext", pt, ct);
    issue_cmd(cmd_decrypt, sel, ct, noisy, rt);
    check_equal("data_o", pt, rt);
  endtask

  task automatic digest_run(input logic [sel_width-1:0] sel, input logic [63:0] a,
                            input logic [63:0] b, input bit interleave,
                            output logic [63:0] d);
    logic [block_width-1:0] unused;
    issue_cmd(cmd_digest_init, sel, '0, 1'b0, unused);
    issue_cmd(cmd_load_shadow, sel, a, 1'b0, unused);
    if (interleave) round_trip(2'd2, 1'b0);
    issue_cmd(cmd_digest, sel, b, interleave, unused);
    if (interleave) round_trip(2'd1, 1'b1);
    issue_cmd(cmd_digest_finalize, sel, '0, 1'b0, d);
  endtask

  // output must read zero outside the result pulse
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && valid_o !== 1'b1) begin
      check_equal("data_o", 64'd0, data_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [block_width-1:0] pt, ct0, ct1, a, b, d1, d2;
    rst_ni  <= 1'b0;
    cmd_i   <= cmd_decrypt;
    sel_i   <= '0;
    data_i  <= '0;
    valid_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_equal("ready_o", 64'd1, 64'(ready_o));
    check_equal("valid_o", 64'd0, 64'(valid_o));

    // round trip under every key, half of them with busy noise
    for (int s = 0; s < num_keys; s++) begin
      for (int n = 0; n < 8; n++) begin
        round_trip(sel_width'(s), n[0]);
      end
    end

    random_block(pt);
    issue_cmd(cmd_encrypt, 2'd0, pt, 1'b0, ct0);
    issue_cmd(cmd_encrypt, 2'd1, pt, 1'b0, ct1);
    check_differ("ciphertexts under sel 0 and sel 1", ct0, ct1);

    // digest, then again with traffic in between
    random_block(a);
    random_block(b);
    digest_run(2'd0, a, b, 1'b0, d1);
    digest_run(2'd0, a, b, 1'b1, d2);
    check_equal("data_o", d1, d2);
    digest_run(2'd0, a, b ^ 64'd1, 1'b0, d2);
    check_differ("digests for different blocks", d1, d2);
    digest_run(2'd1, a, b, 1'b0, d2);
    check_differ("digests for different sets", d1, d2);

    repeat (4) @(posedge clk_i);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: common/present_pkg.sv
////////////////////////////////////////////////////////////
// PRESENT-128 cipher math shared by the round logic
// S-box, bit permutation and key schedule, both directions
////////////////////////////////////////////////////////////

package present_pkg;

  // 4-bit substitution box
  function automatic logic [3:0] sbox(input logic [3:0] x);
    logic [3:0] y;
    case (x)
      4'h0: y = 4'hc;
      4'h1: y = 4'h5;
      4'h2: y = 4'h6;
      4'h3: y = 4'hb;
      4'h4: y = 4'h9;
      4'h5: y = 4'h0;
      4'h6: y = 4'ha;
      4'h7: y = 4'hd;
      4'h8: y = 4'h3;
      4'h9: y = 4'he;
      4'ha: y = 4'hf;
      4'hb: y = 4'h8;
      4'hc: y = 4'h4;
      4'hd: y = 4'h7;
      4'he: y = 4'h1;
      default: y = 4'h2;
    endcase
    return y;
  endfunction

  // inverse box, table read back from sbox
  function automatic logic [3:0] sbox_inv(input logic [3:0] x);
    logic [3:0] y;
    case (x)
      4'h0: y = 4'h5;
      4'h1: y = 4'he;
      4'h2: y = 4'hf;
      4'h3: y = 4'h8;
      4'h4: y = 4'hc;
      4'h5: y = 4'h1;
      4'h6: y = 4'h2;
      4'h7: y = 4'hd;
      4'h8: y = 4'hb;
      4'h9: y = 4'h4;
      4'ha: y = 4'h6;
      4'hb: y = 4'h3;
      4'hc: y = 4'h0;
      4'hd: y = 4'h7;
      4'he: y = 4'h9;
      default: y = 4'ha;
    endcase
    return y;
  endfunction

  // bit i moves to 16*i mod 63, bit 63 stays in place
  function automatic logic [63:0] perm(input logic [63:0] s);
    logic [63:0] p;
    for (int i = 0; i < 63; i++) begin
      p[(16 * i) % 63] = s[i];
    end
    p[63] = s[63];
    return p;
  endfunction

  function automatic logic [63:0] perm_inv(input logic [63:0] s);
    logic [63:0] p;
    for (int i = 0; i < 63; i++) begin
      p[i] = s[(16 * i) % 63];
    end
    p[63] = s[63];
    return p;
  endfunction

  // rotate left by 61, two top nibbles through the box, round index into bits 66:62
  function automatic logic [127:0] key_update(input logic [127:0] k, input logic [4:0] idx);
    logic [127:0] r;
    r = {k[66:0], k[127:67]};
    r[127:124] = sbox(r[127:124]);
    r[123:120] = sbox(r[123:120]);
    r[66:62] = r[66:62] ^ idx;
    return r;
  endfunction

  // undoes key_update for the same round index
  function automatic logic [127:0] key_update_inv(input logic [127:0] k, input logic [4:0] idx);
    logic [127:0] r;
    r = k;
    r[66:62] = r[66:62] ^ idx;
    r[127:124] = sbox_inv(r[127:124]);
    r[123:120] = sbox_inv(r[123:120]);
    return {r[60:0], r[127:61]};
  endfunction

  // run the schedule forward over all rounds to get the key decryption starts from
  function automatic logic [127:0] dec_key_of(input logic [127:0] key, input logic [4:0] rounds);
    logic [127:0] k;
    k = key;
    for (int i = 1; i <= int'(rounds); i++) begin
      k = key_update(k, 5'(i));
    end
    return k;
  endfunction

endpackage

// File: common/scrmbl_ctrl_if.sv
////////////////////////////////////////////////////////////
// control lines from the sequencing FSM to the datapath
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface scrmbl_ctrl_if;
  import scrmbl_pkg::*;

  // mux selects for the working registers
  data_sel_e data_sel;
  key_sel_e  key_sel;

  // register enables, single cycle
  logic data_en;
  logic key_en;
  logic shadow_load;
  logic digest_en;
  // digest register takes the IV instead of the feed-forward
  logic digest_init;

  // result is on the data state
  logic out_valid;

  modport fsm (
    output data_sel, key_sel, data_en, key_en,
    output shadow_load, digest_en, digest_init, out_valid
  );

  modport dp (
    input data_sel, key_sel, data_en, key_en,
    input shadow_load, digest_en, digest_init, out_valid
  );

endinterface

// File: common/scrmbl_pkg.sv
////////////////////////////////////////////////////////////
// scrambler command set, sizes, selects and constant tables
////////////////////////////////////////////////////////////

package scrmbl_pkg;

  // block and key sizes of the cipher
  localparam int block_width = 64;
  localparam int key_width = 128;

  // rounds per command, index counts 1..num_rounds
  localparam int num_rounds = 31;
  typedef logic [4:0] round_idx_t;

  // table sizes and the select input covering both
  localparam int num_keys = 3;
  localparam int num_digest_sets = 2;
  localparam int sel_width = 2;

  // lookups are padded up to a power of two
  localparam int key_idx_width = $clog2(num_keys);
  localparam int digest_idx_width = $clog2(num_digest_sets);
  localparam int key_lut_size = 2 ** key_idx_width;
  localparam int digest_lut_size = 2 ** digest_idx_width;

  typedef enum logic [2:0] {
    cmd_decrypt         = 3'd0,
    cmd_encrypt         = 3'd1,
    cmd_load_shadow     = 3'd2,
    cmd_digest          = 3'd3,
    cmd_digest_init     = 3'd4,
    cmd_digest_finalize = 3'd5
  } scrmbl_cmd_e;

  // next data state source
  typedef enum logic [2:0] {
    sel_enc_out,
    sel_dec_out,
    sel_digest_state,
    sel_enc_xor,
    sel_data_in
  } data_sel_e;

  // next key state source
  typedef enum logic [2:0] {
    ksel_enc_round,
    ksel_dec_round,
    ksel_enc_table,
    ksel_dec_table,
    ksel_digest_const,
    ksel_digest_in
  } key_sel_e;

  localparam logic [key_width-1:0] key_table [num_keys] = '{
    128'h3ba1_21c5_e097_ddf9_c5d8_3b3c_4bba_cc44,
    128'h9e6f_0a42_d718_b3c5_64e1_2f8d_07ac_915b,
    128'h5c27_e8b0_41fd_9a36_c8f2_1d74_b06e_2a93
  };

  // finalization keys for the last digest step
  localparam logic [key_width-1:0] digest_const_table [num_digest_sets] = '{
    128'hd4a8_6f13_2bc9_e075_9f31_5ae6_0c8d_47b2,
    128'h71e3_b9c4_05da_8f62_2e97_c150_6ab8_f34d
  };

  // starting digest state per set
  localparam logic [block_width-1:0] digest_iv_table [num_digest_sets] = '{
    64'h8a3f_61d2_c94e_07b5,
    64'h2d76_e0b9_5f18_a3c4
  };

endpackage

// File: hw/present/present_round.sv
////////////////////////////////////////////////////////////
// one combinational PRESENT round with its key schedule step
// set decrypt for the inverse round
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module present_round #(
  parameter bit decrypt = 1'b0
) (
  input  logic [63:0]  data_i,
  input  logic [127:0] key_i,
  input  logic [4:0]   idx_i,
  output logic [63:0]  data_o,
  output logic [127:0] key_o,
  output logic [4:0]   idx_o
);
  import present_pkg::*;

  if (decrypt) begin : gen_dec
    logic [63:0] perm_out;
    logic [63:0] sub_out;

    // step the key back first, the round being undone used that key
    assign key_o = key_update_inv(key_i, idx_i);
    assign perm_out = perm_inv(data_i);

    always_comb begin
      for (int n = 0; n < 16; n++) begin
        sub_out[4*n +: 4] = sbox_inv(perm_out[4*n +: 4]);
      end
    end

    // round key is the upper half of the key state
    assign data_o = sub_out ^ key_o[127:64];
    assign idx_o = idx_i - 5'd1;

  end else begin : gen_enc
    logic [63:0] ark_out;
    logic [63:0] sub_out;

    // add round key from the current key state
    assign ark_out = data_i ^ key_i[127:64];

    always_comb begin
      for (int n = 0; n < 16; n++) begin
        sub_out[4*n +: 4] = sbox(ark_out[4*n +: 4]);
      end
    end

    assign data_o = perm(sub_out);
    // key for the next round
    assign key_o = key_update(key_i, idx_i);
    assign idx_o = idx_i + 5'd1;
  end

endmodule

// File: hw/scrmbl/scrmbl_datapath.sv
////////////////////////////////////////////////////////////
// scrambler working registers, table lookups and round logic
// steered cycle by cycle through the control interface
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module scrmbl_datapath (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [scrmbl_pkg::sel_width-1:0]   sel_i,
  input  logic [scrmbl_pkg::block_width-1:0] data_i,
  output logic [scrmbl_pkg::block_width-1:0] data_o,
  scrmbl_ctrl_if.dp                          ctrl
);
  import scrmbl_pkg::*;
  import present_pkg::*;

  ////////////////////////////////////////////////////////////
  // constant lookups
  ////////////////////////////////////////////////////////////

  logic [key_width-1:0]   enc_key_lut      [key_lut_size];
  logic [key_width-1:0]   dec_key_lut      [key_lut_size];
  logic [key_width-1:0]   digest_const_lut [digest_lut_size];
  logic [block_width-1:0] digest_iv_lut    [digest_lut_size];

  // unused pad entries read as zero
  for (genvar k = 0; k < key_lut_size; k++) begin : gen_key_lut
    if (k < num_keys) begin : gen_used
      // decrypt starts from the last round key
      localparam logic [key_width-1:0] dec_key =
          dec_key_of(key_table[k], round_idx_t'(num_rounds));
      assign enc_key_lut[k] = key_table[k];
      assign dec_key_lut[k] = dec_key;
    end else begin : gen_pad
      assign enc_key_lut[k] = '0;
      assign dec_key_lut[k] = '0;
    end
  end

  for (genvar k = 0; k < digest_lut_size; k++) begin : gen_digest_lut
    if (k < num_digest_sets) begin : gen_used
      assign digest_const_lut[k] = digest_const_table[k];
      assign digest_iv_lut[k]    = digest_iv_table[k];
    end else begin : gen_pad
      assign digest_const_lut[k] = '0;
      assign digest_iv_lut[k]    = '0;
    end
  end

  logic [key_width-1:0]   enc_key_mux, dec_key_mux, digest_const_mux;
  logic [block_width-1:0] digest_iv_mux;

  assign enc_key_mux      = enc_key_lut[sel_i[key_idx_width-1:0]];
  assign dec_key_mux      = dec_key_lut[sel_i[key_idx_width-1:0]];
  assign digest_const_mux = digest_const_lut[sel_i[digest_idx_width-1:0]];
  assign digest_iv_mux    = digest_iv_lut[sel_i[digest_idx_width-1:0]];

  ////////////////////////////////////////////////////////////
  // rounds and next state muxing
  ////////////////////////////////////////////////////////////

  logic [key_width-1:0]   key_state_d, key_state_q, enc_key_out, dec_key_out;
  round_idx_t             idx_state_d, idx_state_q, enc_idx_out, dec_idx_out;
  logic [block_width-1:0] data_state_d, data_state_q, data_shadow_q;
  logic [block_width-1:0] digest_state_d, digest_state_q;
  logic [block_width-1:0] enc_data_out, dec_data_out, enc_xor;

  present_round #(.decrypt(1'b0)) u_enc_round (
    .data_i (data_state_q),
    .key_i  (key_state_q),
    .idx_i  (idx_state_q),
    .data_o (enc_data_out),
    .key_o  (enc_key_out),
    .idx_o  (enc_idx_out)
  );

  present_round #(.decrypt(1'b1)) u_dec_round (
    .data_i (data_state_q),
    .key_i  (key_state_q),
    .idx_i  (idx_state_q),
    .data_o (dec_data_out),
    .key_o  (dec_key_out),
    .idx_o  (dec_idx_out)
  );

  // davies-meyer feed-forward
  assign enc_xor = enc_data_out ^ digest_state_q;

  always_comb begin
    case (ctrl.data_sel)
      sel_enc_out:      data_state_d = enc_data_out;
      sel_dec_out:      data_state_d = dec_data_out;
      sel_digest_state: data_state_d = digest_state_q;
      sel_enc_xor:      data_state_d = enc_xor;
      default:          data_state_d = data_i;
    endcase

    // digest input key is the new block over the shadow half
    case (ctrl.key_sel)
      ksel_enc_round:    key_state_d = enc_key_out;
      ksel_dec_round:    key_state_d = dec_key_out;
      ksel_enc_table:    key_state_d = enc_key_mux;
      ksel_dec_table:    key_state_d = dec_key_mux;
      ksel_digest_const: key_state_d = digest_const_mux;
      default:           key_state_d = {data_i, data_shadow_q};
    endcase

    // index counts down from the top for decrypt, up from 1 otherwise
    case (ctrl.key_sel)
      ksel_enc_round: idx_state_d = enc_idx_out;
      ksel_dec_round: idx_state_d = dec_idx_out;
      ksel_dec_table: idx_state_d = round_idx_t'(num_rounds);
      default:        idx_state_d = round_idx_t'(1);
    endcase
  end

  assign digest_state_d = ctrl.digest_init ? digest_iv_mux : enc_xor;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_state_q    <= '0;
      idx_state_q    <= '0;
      data_state_q   <= '0;
      data_shadow_q  <= '0;
      digest_state_q <= '0;
    end else begin
      if (ctrl.key_en) begin
        key_state_q <= key_state_d;
        idx_state_q <= idx_state_d;
      end
      if (ctrl.data_en) begin
        data_state_q <= data_state_d;
      end
      if (ctrl.shadow_load) begin
        data_shadow_q <= data_i;
      end
      if (ctrl.digest_en) begin
        digest_state_q <= digest_state_d;
      end
    end
  end

  // result only shows during the valid cycle
  assign data_o = ctrl.out_valid ? data_state_q : '0;

endmodule

// File: hw/scrmbl/scrmbl_fsm.sv
////////////////////////////////////////////////////////////
// command decode and round sequencing for the scrambler
// drives the datapath selects and the valid/ready handshake
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module scrmbl_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output logic                    valid_o,
  scrmbl_ctrl_if.fsm              ctrl
);
  import scrmbl_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_decrypt,
    st_encrypt,
    st_digest
  } state_e;

  state_e     state_d, state_q;
  round_idx_t cnt_d, cnt_q;
  logic       last_round;
  logic       valid_d, valid_q;

  data_sel_e  data_sel;
  key_sel_e   key_sel;
  logic       data_en, key_en, shadow_load, digest_en, digest_init;

  // counter holds rounds done so far
  assign last_round = (cnt_q == round_idx_t'(num_rounds - 1));

  ////////////////////////////////////////////////////////////
  // next state and control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q;
    valid_d     = 1'b0;
    ready_o     = 1'b0;
    data_sel    = sel_data_in;
    key_sel     = ksel_digest_in;
    data_en     = 1'b0;
    key_en      = 1'b0;
    shadow_load = 1'b0;
    digest_en   = 1'b0;
    digest_init = 1'b0;

    case (state_q)
      st_idle: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          case (cmd_i)
            cmd_decrypt: begin
              state_d = st_decrypt;
              key_sel = ksel_dec_table;
              data_en = 1'b1;
              key_en  = 1'b1;
            end
            cmd_encrypt: begin
              state_d = st_encrypt;
              key_sel = ksel_enc_table;
              data_en = 1'b1;
              key_en  = 1'b1;
            end
            // lower half of the next digest key
            cmd_load_shadow: shadow_load = 1'b1;
            cmd_digest: begin
              state_d  = st_digest;
              data_sel = sel_digest_state;
              key_sel  = ksel_digest_in;
              data_en  = 1'b1;
              key_en   = 1'b1;
            end
            cmd_digest_init: begin
              digest_init = 1'b1;
              digest_en   = 1'b1;
            end
            cmd_digest_finalize: begin
              state_d  = st_digest;
              data_sel = sel_digest_state;
              key_sel  = ksel_digest_const;
              data_en  = 1'b1;
              key_en   = 1'b1;
            end
            default: ;
          endcase
        end
      end
      st_decrypt: begin
        data_sel = sel_dec_out;
        key_sel  = ksel_dec_round;
        data_en  = 1'b1;
        key_en   = 1'b1;
        cnt_d    = cnt_q + round_idx_t'(1);
        if (last_round) begin
          state_d = st_idle;
          valid_d = 1'b1;
        end
      end
      st_encrypt: begin
        data_sel = sel_enc_out;
        key_sel  = ksel_enc_round;
        data_en  = 1'b1;
        key_en   = 1'b1;
        cnt_d    = cnt_q + round_idx_t'(1);
        if (last_round) begin
          state_d = st_idle;
          valid_d = 1'b1;
        end
      end
      // digest steps run the forward cipher
      st_digest: begin
        data_sel = sel_enc_out;
        key_sel  = ksel_enc_round;
        data_en  = 1'b1;
        key_en   = 1'b1;
        cnt_d    = cnt_q + round_idx_t'(1);
        if (last_round) begin
          state_d = st_idle;
          valid_d = 1'b1;
          // davies-meyer feed-forward, kept apart so encrypts can interleave
          data_sel  = sel_enc_xor;
          digest_en = 1'b1;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

  assign valid_o = valid_q;

  // control out to the datapath
  assign ctrl.data_sel    = data_sel;
  assign ctrl.key_sel     = key_sel;
  assign ctrl.data_en     = data_en;
  assign ctrl.key_en      = key_en;
  assign ctrl.shadow_load = shadow_load;
  assign ctrl.digest_en   = digest_en;
  assign ctrl.digest_init = digest_init;
  assign ctrl.out_valid   = valid_q;

endmodule

// File: hw/scrmbl_top.sv
////////////////////////////////////////////////////////////
// scrambler top level, one command in flight at a time
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module scrmbl_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // command side
  input  scrmbl_pkg::scrmbl_cmd_e            cmd_i,
  input  logic [scrmbl_pkg::sel_width-1:0]   sel_i,
  input  logic [scrmbl_pkg::block_width-1:0] data_i,
  input  logic                               valid_i,
  output logic                               ready_o,
  // result side, one-cycle pulse
  output logic [scrmbl_pkg::block_width-1:0] data_o,
  output logic                               valid_o
);

  scrmbl_ctrl_if u_ctrl_if ();

  scrmbl_fsm u_fsm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ctrl    (u_ctrl_if.fsm)
  );

  scrmbl_datapath u_datapath (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sel_i  (sel_i),
    .data_i (data_i),
    .data_o (data_o),
    .ctrl   (u_ctrl_if.dp)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the scrambler testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_scrmbl \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$log"; then
  exit 1
fi
exit 0

// File: src.f
common/present_pkg.sv
common/scrmbl_pkg.sv
common/scrmbl_ctrl_if.sv
hw/present/present_round.sv
hw/scrmbl/scrmbl_fsm.sv
hw/scrmbl/scrmbl_datapath.sv
hw/scrmbl_top.sv
bench/scrmbl_props.sv
bench/tb_scrmbl.sv
